// File: bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Fetch slots and resolve slots handled per cycle
`define FETCH_WIDTH 2

// Width of every table index and of the global history
`define HISTORY_BITS 8

`define TABLE_SIZE (1 << `HISTORY_BITS)

// Instructions are word aligned, so the index skips the two low PC bits
`define PC_INDEX_LSB 2

// Weakly not-taken
`define COUNTER_RESET 2'd1

`endif

// File: bp_pkg.sv
`default_nettype none
`include "bp_macros.svh"

package bp_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [`HISTORY_BITS-1:0] index_t;
    typedef logic [`HISTORY_BITS-1:0] history_t; // Newest outcome in bit 0
    typedef logic [1:0] counter_t; // Values 2 and 3 predict taken

    typedef enum logic [1:0] {
        bimodal_strong = 2'd0,
        bimodal_weak   = 2'd1,
        gshare_weak    = 2'd2,
        gshare_strong  = 2'd3
    } sel_state_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t pc;
    } resolve_t;

    typedef struct packed {
        logic taken;
        logic use_gshare;
    } prediction_t;

    function automatic index_t pc_index(input addr_t pc);
        return pc[`PC_INDEX_LSB +: `HISTORY_BITS];
    endfunction

    // One training step of a saturating direction counter
    function automatic counter_t counter_step(input counter_t value, input logic taken);
        counter_t result;
        result = value;
        if (taken && value != 2'd3) begin
            result = value + 2'd1;
        end else if (!taken && value != 2'd0) begin
            result = value - 2'd1;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: bimodal_predictor.sv
`default_nettype none
`include "bp_macros.svh"

module bimodal_predictor (
    input  logic                                 clock,
    input  logic                                 reset,
    input  bp_pkg::addr_t    [`FETCH_WIDTH-1:0]  fetch_pc,
    input  bp_pkg::resolve_t [`FETCH_WIDTH-1:0]  resolve,
    output logic             [`FETCH_WIDTH-1:0]  taken,
    output logic             [`FETCH_WIDTH-1:0]  correct
);

    bp_pkg::counter_t [`TABLE_SIZE-1:0]  counter_table;
    bp_pkg::index_t   [`FETCH_WIDTH-1:0] fetch_index;
    bp_pkg::index_t   [`FETCH_WIDTH-1:0] resolve_index;
    bp_pkg::counter_t [`FETCH_WIDTH-1:0] next_counter;

    // Fetch read port
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fetch_index[i] = bp_pkg::pc_index(fetch_pc[i]);
            taken[i] = counter_table[fetch_index[i]][1];
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            resolve_index[i] = bp_pkg::pc_index(resolve[i].pc);
            correct[i] = (counter_table[resolve_index[i]][1] == resolve[i].taken);
            // Both slots step from the old entry
            next_counter[i] = bp_pkg::counter_step(counter_table[resolve_index[i]],
                                                   resolve[i].taken);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int e = 0; e < `TABLE_SIZE; e++) begin
                counter_table[e] <= `COUNTER_RESET;
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (resolve[i].valid) begin
                    counter_table[resolve_index[i]] <= next_counter[i]; // Later slot wins
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: gshare_predictor.sv
`default_nettype none
`include "bp_macros.svh"

module gshare_predictor (
    input  logic                                 clock,
    input  logic                                 reset,
    input  bp_pkg::addr_t    [`FETCH_WIDTH-1:0]  fetch_pc,
    input  bp_pkg::resolve_t [`FETCH_WIDTH-1:0]  resolve,
    output logic             [`FETCH_WIDTH-1:0]  taken,
    output logic             [`FETCH_WIDTH-1:0]  correct
);

    bp_pkg::counter_t [`TABLE_SIZE-1:0]  counter_table;
    bp_pkg::history_t                    history;
    bp_pkg::history_t                    history_next;
    bp_pkg::index_t   [`FETCH_WIDTH-1:0] fetch_index;
    bp_pkg::index_t   [`FETCH_WIDTH-1:0] resolve_index;
    bp_pkg::counter_t [`FETCH_WIDTH-1:0] next_counter;

    // Fetch lookups hash with the committed history
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fetch_index[i] = bp_pkg::pc_index(fetch_pc[i]) ^ history;
            taken[i] = counter_table[fetch_index[i]][1];
        end
    end

    // Every resolve slot uses the history from before this edge
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            resolve_index[i] = bp_pkg::pc_index(resolve[i].pc) ^ history;
            correct[i] = (counter_table[resolve_index[i]][1] == resolve[i].taken);
            next_counter[i] = bp_pkg::counter_step(counter_table[resolve_index[i]],
                                                   resolve[i].taken);
        end
    end

    // Valid outcomes shift in slot order, so the last valid slot lands in bit 0
    always_comb begin
        history_next = history;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (resolve[i].valid) begin
                history_next = {history_next[`HISTORY_BITS-2:0], resolve[i].taken};
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            history <= '0;
        end else begin
            history <= history_next;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int e = 0; e < `TABLE_SIZE; e++) begin
                counter_table[e] <= `COUNTER_RESET;
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (resolve[i].valid) begin
                    counter_table[resolve_index[i]] <= next_counter[i]; // Later slot wins
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: predictor_selector.sv
`default_nettype none
`include "bp_macros.svh"

module predictor_selector (
    input  logic                               clock,
    input  logic                               reset,
    input  bp_pkg::addr_t  [`FETCH_WIDTH-1:0]  fetch_pc,
    input  bp_pkg::addr_t  [`FETCH_WIDTH-1:0]  resolve_pc,
    input  logic           [`FETCH_WIDTH-1:0]  enable,
    input  logic           [`FETCH_WIDTH-1:0]  bimodal_correct,
    input  logic           [`FETCH_WIDTH-1:0]  gshare_correct,
    output logic           [`FETCH_WIDTH-1:0]  use_gshare
);

    bp_pkg::sel_state_t [`TABLE_SIZE-1:0]  chooser_table;
    bp_pkg::index_t     [`FETCH_WIDTH-1:0] fetch_index;
    bp_pkg::index_t     [`FETCH_WIDTH-1:0] resolve_index;
    bp_pkg::sel_state_t [`FETCH_WIDTH-1:0] current_state;
    bp_pkg::sel_state_t [`FETCH_WIDTH-1:0] next_state;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fetch_index[i] = bp_pkg::pc_index(fetch_pc[i]);
            use_gshare[i] = chooser_table[fetch_index[i]][1]; // High half of the encoding is gshare
        end
    end

    // Only a disagreement in correctness moves the chooser
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            resolve_index[i] = bp_pkg::pc_index(resolve_pc[i]);
            current_state[i] = chooser_table[resolve_index[i]];
            next_state[i] = current_state[i];
            if (gshare_correct[i] && !bimodal_correct[i]) begin
                if (current_state[i] != bp_pkg::gshare_strong) begin
                    next_state[i] = bp_pkg::sel_state_t'(current_state[i] + 2'd1);
                end
            end else if (bimodal_correct[i] && !gshare_correct[i]) begin
                if (current_state[i] != bp_pkg::bimodal_strong) begin
                    next_state[i] = bp_pkg::sel_state_t'(current_state[i] - 2'd1);
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int e = 0; e < `TABLE_SIZE; e++) begin
                chooser_table[e] <= bp_pkg::bimodal_weak;
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (enable[i]) begin
                    chooser_table[resolve_index[i]] <= next_state[i]; // Later slot wins
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hybrid_predictor.sv
`default_nettype none
`include "bp_macros.svh"

module hybrid_predictor (
    input  logic                                   clock,
    input  logic                                   reset,
    input  bp_pkg::addr_t       [`FETCH_WIDTH-1:0] fetch_pc,
    input  bp_pkg::resolve_t    [`FETCH_WIDTH-1:0] resolve,
    output bp_pkg::prediction_t [`FETCH_WIDTH-1:0] prediction
);

    logic          [`FETCH_WIDTH-1:0] bimodal_taken;
    logic          [`FETCH_WIDTH-1:0] bimodal_correct;
    logic          [`FETCH_WIDTH-1:0] gshare_taken;
    logic          [`FETCH_WIDTH-1:0] gshare_correct;
    logic          [`FETCH_WIDTH-1:0] use_gshare;
    logic          [`FETCH_WIDTH-1:0] resolve_valid;
    bp_pkg::addr_t [`FETCH_WIDTH-1:0] resolve_pc;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            resolve_valid[i] = resolve[i].valid;
            resolve_pc[i] = resolve[i].pc;
        end
    end

    bimodal_predictor bimodal_i (
        .clock   (clock),
        .reset   (reset),
        .fetch_pc(fetch_pc),
        .resolve (resolve),
        .taken   (bimodal_taken),
        .correct (bimodal_correct)
    );

    gshare_predictor gshare_i (
        .clock   (clock),
        .reset   (reset),
        .fetch_pc(fetch_pc),
        .resolve (resolve),
        .taken   (gshare_taken),
        .correct (gshare_correct)
    );

    // The chooser is indexed by the plain PC, not the hashed gshare index
    predictor_selector selector_i (
        .clock          (clock),
        .reset          (reset),
        .fetch_pc       (fetch_pc),
        .resolve_pc     (resolve_pc),
        .enable         (resolve_valid),
        .bimodal_correct(bimodal_correct),
        .gshare_correct (gshare_correct),
        .use_gshare     (use_gshare)
    );

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            prediction[i].taken = use_gshare[i] ? gshare_taken[i] : bimodal_taken[i];
            prediction[i].use_gshare = use_gshare[i];
        end
    end

endmodule

`default_nettype wire

// File: hybrid_predictor_chk.sv
`default_nettype none
`include "bp_macros.svh"

module hybrid_predictor_chk (
    input logic                                   clock,
    input logic                                   reset,
    input bp_pkg::resolve_t    [`FETCH_WIDTH-1:0] resolve,
    input bp_pkg::prediction_t [`FETCH_WIDTH-1:0] prediction,
    input logic                [`FETCH_WIDTH-1:0] bimodal_taken
);

    int failure_count = 0;

    prediction_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(prediction))
        else begin
            failure_count++;
            $error("Prediction is unknown outside reset");
        end

    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : slot_checks
        valid_pc_known: assert property (@(posedge clock) disable iff (reset)
            resolve[i].valid |-> !$isunknown(resolve[i].pc))
            else begin
                failure_count++;
                $error("Valid resolve in slot %0d carries an unknown PC", i);
            end

        // With the chooser on bimodal the final direction is the bimodal one
        bimodal_choice: assert property (@(posedge clock) disable iff (reset)
            !prediction[i].use_gshare |-> prediction[i].taken == bimodal_taken[i])
            else begin
                failure_count++;
                $error("Slot %0d taken differs from the bimodal direction", i);
            end
    end

endmodule

bind hybrid_predictor hybrid_predictor_chk chk_i (
    .clock        (clock),
    .reset        (reset),
    .resolve      (resolve),
    .prediction   (prediction),
    .bimodal_taken(bimodal_taken)
);

`default_nettype wire

// File: hybrid_predictor_tb.sv
`default_nettype none
`include "bp_macros.svh"

module hybrid_predictor_tb;

    localparam int clock_period = 10;
    localparam int reset_cycles = 10;
    localparam int random_rows = 200;

    typedef struct packed {
        bp_pkg::addr_t       [`FETCH_WIDTH-1:0] fetch_pc;
        bp_pkg::resolve_t    [`FETCH_WIDTH-1:0] resolve;
        bp_pkg::prediction_t [`FETCH_WIDTH-1:0] expected;
    } row_t;

    logic                                   clock;
    logic                                   reset;
    bp_pkg::addr_t       [`FETCH_WIDTH-1:0] fetch_pc;
    bp_pkg::resolve_t    [`FETCH_WIDTH-1:0] resolve;
    bp_pkg::prediction_t [`FETCH_WIDTH-1:0] prediction;

    row_t             rows[$];
    bit               table_ready = 1'b0;
    int               bimodal_model[`TABLE_SIZE];
    int               gshare_model[`TABLE_SIZE];
    int               chooser_model[`TABLE_SIZE];
    bp_pkg::history_t history_model;
    bp_pkg::addr_t    pc_pool[6];

    hybrid_predictor dut_i (
        .clock     (clock),
        .reset     (reset),
        .fetch_pc  (fetch_pc),
        .resolve   (resolve),
        .prediction(prediction)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic int table_index(input bp_pkg::addr_t pc);
        return int'((pc >> 2) & (`TABLE_SIZE - 1));
    endfunction

    function automatic int clamp(input int value);
        return (value < 0) ? 0 : ((value > 3) ? 3 : value);
    endfunction

    function automatic bp_pkg::resolve_t resolved(input bp_pkg::addr_t pc, input logic taken);
        bp_pkg::resolve_t r;
        r.valid = 1'b1;
        r.taken = taken;
        r.pc = pc;
        return r;
    endfunction

    task automatic add_row(input bp_pkg::addr_t pc0, input bp_pkg::addr_t pc1,
                           input bp_pkg::resolve_t r0, input bp_pkg::resolve_t r1);
        row_t row;
        row = '0;
        row.fetch_pc[0] = pc0;
        row.fetch_pc[1] = pc1;
        row.resolve[0] = r0;
        row.resolve[1] = r1;
        rows.push_back(row);
    endtask

    function automatic bp_pkg::prediction_t model_predict(input bp_pkg::addr_t pc);
        bp_pkg::prediction_t p;
        int bi;
        int gi;
        bi = table_index(pc);
        gi = bi ^ int'(history_model);
        p.use_gshare = (chooser_model[bi] >= 2);
        p.taken = p.use_gshare ? (gshare_model[gi] >= 2) : (bimodal_model[bi] >= 2);
        return p;
    endfunction

    // All slots read the old tables and the old history before anything is written
    task automatic model_train(input row_t row);
        int  bi[`FETCH_WIDTH];
        int  gi[`FETCH_WIDTH];
        int  nb[`FETCH_WIDTH];
        int  ng[`FETCH_WIDTH];
        int  ns[`FETCH_WIDTH];
        int  step;
        bit  bimodal_ok;
        bit  gshare_ok;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            bi[i] = table_index(row.resolve[i].pc);
            gi[i] = bi[i] ^ int'(history_model);
            bimodal_ok = ((bimodal_model[bi[i]] >= 2) == row.resolve[i].taken);
            gshare_ok = ((gshare_model[gi[i]] >= 2) == row.resolve[i].taken);
            step = row.resolve[i].taken ? 1 : -1;
            nb[i] = clamp(bimodal_model[bi[i]] + step);
            ng[i] = clamp(gshare_model[gi[i]] + step);
            ns[i] = chooser_model[bi[i]];
            if (gshare_ok && !bimodal_ok) begin
                ns[i] = clamp(ns[i] + 1);
            end else if (bimodal_ok && !gshare_ok) begin
                ns[i] = clamp(ns[i] - 1);
            end
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (row.resolve[i].valid) begin
                bimodal_model[bi[i]] = nb[i];
                gshare_model[gi[i]] = ng[i];
                chooser_model[bi[i]] = ns[i];
                history_model = {history_model[`HISTORY_BITS-2:0], row.resolve[i].taken};
            end
        end
    endtask

    task automatic fill_expected();
        row_t row;
        for (int e = 0; e < `TABLE_SIZE; e++) begin
            bimodal_model[e] = 1;
            gshare_model[e] = 1;
            chooser_model[e] = 1;
        end
        history_model = '0;
        for (int k = 0; k < rows.size(); k++) begin
            row = rows[k];
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                row.expected[i] = model_predict(row.fetch_pc[i]);
            end
            rows[k] = row;
            model_train(row);
        end
    endtask

    task automatic build_directed_rows();
        bp_pkg::addr_t    a;
        bp_pkg::addr_t    b;
        bp_pkg::addr_t    c;
        bp_pkg::addr_t    d;
        bp_pkg::resolve_t none;
        a = 32'h0000_1000;
        b = 32'h0000_2040;
        c = 32'h0000_3008;
        d = 32'h0000_1400; // Same table index as a
        none = '0;
        add_row(a, b, none, none);
        add_row(c, d, none, none);
        // Bimodal training and saturation at one PC
        add_row(a, c, resolved(a, 1'b1), none);
        add_row(a, c, resolved(a, 1'b1), none);
        add_row(a, c, none, none);
        add_row(a, c, resolved(a, 1'b1), none);
        add_row(a, c, resolved(a, 1'b0), none);
        add_row(a, c, resolved(a, 1'b0), none);
        add_row(a, c, none, none);
        // An alternating branch only gshare can follow
        for (int k = 0; k < 32; k++) begin
            add_row(b, a, resolved(b, logic'(k % 2)), none);
        end
        // Steady taken branch next to a noisy one pushes its chooser to the bimodal end
        for (int k = 0; k < 16; k++) begin
            add_row(c, b, resolved(c, 1'b1), resolved(b, logic'(k % 3 == 0)));
        end
        // Two resolves per cycle, including a shared index
        add_row(a, b, resolved(a, 1'b1), resolved(b, 1'b0));
        add_row(a, d, resolved(a, 1'b1), resolved(a, 1'b0));
        add_row(a, d, resolved(d, 1'b0), resolved(a, 1'b1));
        add_row(a, d, resolved(d, 1'b1), resolved(a, 1'b1));
        add_row(a, d, none, none);
    endtask

    task automatic build_random_rows();
        bp_pkg::resolve_t r0;
        bp_pkg::resolve_t r1;
        pc_pool[0] = 32'h0000_1000;
        pc_pool[1] = 32'h0000_1004;
        pc_pool[2] = 32'h0000_2040;
        pc_pool[3] = 32'h0000_3008;
        pc_pool[4] = 32'h0000_1400;
        pc_pool[5] = 32'h0000_00fc;
        for (int k = 0; k < random_rows; k++) begin
            r0 = resolved(pc_pool[$urandom_range(0, 5)], logic'($urandom_range(0, 1)));
            r1 = resolved(pc_pool[$urandom_range(0, 5)], logic'($urandom_range(0, 1)));
            r0.valid = logic'($urandom_range(0, 1));
            r1.valid = logic'($urandom_range(0, 1));
            add_row(pc_pool[$urandom_range(0, 5)], pc_pool[$urandom_range(0, 5)], r0, r1);
        end
    endtask

    task automatic check_prediction(input int row, input int slot,
                                    input bp_pkg::prediction_t actual,
                                    input bp_pkg::prediction_t expected);
        if (actual !== expected) begin
            $display("error at %0t: row %0d slot %0d taken %b expected %b, use_gshare %b expected %b",
                     $time, row, slot, actual.taken, expected.taken,
                     actual.use_gshare, expected.use_gshare);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopping at the first prediction mismatch");
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        fetch_pc = '0;
        resolve = '0;
        void'($urandom(7));
        build_directed_rows();
        build_random_rows();
        fill_expected();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1 reset = 1'b0;
        for (int k = 0; k < rows.size(); k++) begin
            fetch_pc = rows[k].fetch_pc;
            resolve = rows[k].resolve;
            #4; // Middle of the cycle
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                check_prediction(k, i, prediction[i], rows[k].expected[i]);
            end
            @(posedge clock);
            #1;
        end
        resolve = '0;
        @(posedge clock);
        #1;
        if (dut_i.chk_i.failure_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "Checker assertions failed during the run");
        end
    end

    always @(dut_i.chk_i.failure_count) begin
        if (dut_i.chk_i.failure_count != 0) begin
            $display("SIMULATION FAILED");
            $fatal(1, "A checker assertion failed");
        end
    end

    initial begin
        wait (table_ready);
        #(2 * (reset_cycles + rows.size()) * clock_period);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
bp_pkg.sv
bimodal_predictor.sv
gshare_predictor.sv
predictor_selector.sv
hybrid_predictor.sv
hybrid_predictor_chk.sv
hybrid_predictor_tb.sv

// File: Makefile
# Verilator build and run for the hybrid branch predictor

VERILATOR       ?= verilator
TOP             ?= hybrid_predictor_tb
FILE_LIST       ?= list.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
PASS_MESSAGE    ?= SIMULATION PASSED
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only --timing --assert
RUN_ARGS        ?= +verilator+error+limit+100

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MESSAGE)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
